// ==== compile.f ====
rtl/axi_bridge_pkg.sv
rtl/read_arbiter.sv
rtl/ar_issue.sv
rtl/r_return.sv
rtl/write_channel.sv
rtl/axi_cache_bridge.sv
tb/bridge_checker.sv
tb/tb_axi_cache_bridge.sv

// ==== Bender.yml ====
package:
  name: axi_cache_bridge

sources:
  - rtl/axi_bridge_pkg.sv
  - rtl/read_arbiter.sv
  - rtl/ar_issue.sv
  - rtl/r_return.sv
  - rtl/write_channel.sv
  - rtl/axi_cache_bridge.sv
  - target: test
    files:
      - tb/bridge_checker.sv
      - tb/tb_axi_cache_bridge.sv

// ==== tb/tb_axi_cache_bridge.sv ====
`timescale 1ns/1ns

module tb_axi_cache_bridge;

    localparam int NUM_TXN    = 300;
    localparam int MAX_CYCLES = NUM_TXN * 40;

    logic aclk;
    logic aresetn;
    logic ic_rd_req_i, ic_rd_rdy_o, ic_ret_valid_o, ic_ret_last_o;
    logic dc_rd_req_i, dc_rd_rdy_o, dc_ret_valid_o, dc_ret_last_o;
    logic dc_wr_req_i, dc_wr_rdy_o;
    axi_bridge_pkg::req_type_t ic_rd_type_i, dc_rd_type_i, dc_wr_type_i;
    axi_bridge_pkg::addr_t     ic_addr_i, dc_addr_i, dc_wr_addr_i, araddr_o, awaddr_o;
    axi_bridge_pkg::data_t     ic_data_o, dc_data_o, rdata_i, wdata_o;
    axi_bridge_pkg::strb_t     dc_wr_strb_i, wstrb_o;
    axi_bridge_pkg::line_t     dc_wr_line_i;
    axi_bridge_pkg::axi_id_t   arid_o, rid_i;
    axi_bridge_pkg::axi_len_t  arlen_o, awlen_o;
    axi_bridge_pkg::axi_size_t arsize_o, awsize_o;
    logic [1:0] arburst_o, awburst_o;
    logic arvalid_o, arready_i, rvalid_i, rready_o, rlast_i;
    logic awvalid_o, awready_i, wvalid_o, wready_i, wlast_o, bvalid_i, bready_o;

    int err_cnt;
    int chk_cnt;

    logic [31:0] rng;
    logic [31:0] r;
    int started;
    int ic_st, dc_st, wr_st;    // 0 idle, 1 requesting, 2 waiting for ready
    int cycles;
    int r_beat, ar_wait, aw_wait, w_wait, b_wait;
    logic b_pend;

    // read bursts accepted by the slave, served in order
    axi_bridge_pkg::axi_id_t  rq_id[$];
    axi_bridge_pkg::addr_t    rq_addr[$];
    axi_bridge_pkg::axi_len_t rq_len[$];

    axi_cache_bridge u_axi_cache_bridge (.*);
    bridge_checker u_bridge_checker (.*);

    always #5 aclk = ~aclk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] draw();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task serve_ar();
        if (arvalid_o && arready_i) begin
            rq_id.push_back(arid_o);
            rq_addr.push_back(araddr_o);
            rq_len.push_back(arlen_o);
            arready_i <= 1'b0;
            ar_wait = draw() % 4;
        end else if (arvalid_o) begin
            if (ar_wait == 0) arready_i <= 1'b1;
            else ar_wait--;
        end
    endtask

    task serve_r();
        if (rvalid_i && rready_o) begin
            if (r_beat == rq_len[0]) begin
                void'(rq_id.pop_front());
                void'(rq_addr.pop_front());
                void'(rq_len.pop_front());
                r_beat = 0;
            end else begin
                r_beat++;
            end
        end
        if (rq_id.size() > 0) begin
            rvalid_i <= 1'b1;
            rid_i    <= rq_id[0];
            rdata_i  <= (rq_addr[0] + 4 * r_beat) ^ 32'h5A5A0000;
            rlast_i  <= (r_beat == rq_len[0]);
        end else begin
            rvalid_i <= 1'b0;
            rlast_i  <= 1'b0;
        end
    endtask

    task serve_write();
        if (awvalid_o && awready_i) begin
            awready_i <= 1'b0;
            aw_wait = draw() % 4;
        end else if (awvalid_o) begin
            if (aw_wait == 0) awready_i <= 1'b1;
            else aw_wait--;
        end
        if (wvalid_o && wready_i) begin
            wready_i <= 1'b0;
            w_wait = draw() % 4;
            if (wlast_o) begin
                b_pend = 1'b1;
                b_wait = 1 + draw() % 3;
            end
        end else if (wvalid_o) begin
            if (w_wait == 0) wready_i <= 1'b1;
            else w_wait--;
        end
        if (bvalid_i && bready_o) begin
            bvalid_i <= 1'b0;
        end else if (b_pend) begin
            if (b_wait <= 1) begin
                bvalid_i <= 1'b1;
                b_pend = 1'b0;
            end else begin
                b_wait--;
            end
        end
    endtask

    initial begin
        aclk = 1'b0;
        aresetn = 1'b0;
        rng = 32'd62297;
        ic_rd_req_i = 1'b0;
        ic_rd_type_i = axi_bridge_pkg::REQ_WORD;
        ic_addr_i = '0;
        dc_rd_req_i = 1'b0;
        dc_rd_type_i = axi_bridge_pkg::REQ_WORD;
        dc_addr_i = '0;
        dc_wr_req_i = 1'b0;
        dc_wr_type_i = axi_bridge_pkg::REQ_WORD;
        dc_wr_addr_i = '0;
        dc_wr_strb_i = '0;
        dc_wr_line_i = '0;
        arready_i = 1'b0;
        rvalid_i = 1'b0;
        rid_i = '0;
        rdata_i = '0;
        rlast_i = 1'b0;
        awready_i = 1'b0;
        wready_i = 1'b0;
        bvalid_i = 1'b0;
        repeat (8) @(posedge aclk);
        aresetn <= 1'b1;
    end

    always @(posedge aclk) begin
        cycles++;
        if (aresetn) begin
            case (ic_st)
                0: if (started < NUM_TXN && draw() % 4 == 0) begin
                    r = draw();
                    ic_rd_req_i  <= 1'b1;
                    ic_rd_type_i <= r[0] ? axi_bridge_pkg::REQ_LINE : axi_bridge_pkg::REQ_WORD;
                    ic_addr_i    <= {r[31:4], 4'h0};
                    started++;
                    ic_st = 1;
                end
                1: if (!ic_rd_rdy_o) begin
                    ic_rd_req_i <= 1'b0;
                    ic_st = 2;
                end
                default: if (ic_rd_rdy_o) ic_st = 0;
            endcase
            case (dc_st)
                0: if (started < NUM_TXN && draw() % 4 == 0) begin
                    r = draw();
                    dc_rd_req_i  <= 1'b1;
                    dc_rd_type_i <= r[1] ? axi_bridge_pkg::REQ_LINE : axi_bridge_pkg::REQ_WORD;
                    dc_addr_i    <= {r[31:4], 4'h4};
                    started++;
                    dc_st = 1;
                end
                1: if (!dc_rd_rdy_o) begin
                    dc_rd_req_i <= 1'b0;
                    dc_st = 2;
                end
                default: if (dc_rd_rdy_o) dc_st = 0;
            endcase
            case (wr_st)
                0: if (started < NUM_TXN && draw() % 6 == 0) begin
                    r = draw();
                    dc_wr_req_i  <= 1'b1;
                    dc_wr_type_i <= r[2] ? axi_bridge_pkg::REQ_LINE : axi_bridge_pkg::REQ_WORD;
                    dc_wr_addr_i <= {r[31:4], 4'h0};
                    dc_wr_strb_i <= r[7:4];
                    dc_wr_line_i <= {draw(), draw(), draw(), draw()};
                    started++;
                    wr_st = 1;
                end
                1: if (!dc_wr_rdy_o) begin
                    dc_wr_req_i <= 1'b0;
                    wr_st = 2;
                end
                default: if (dc_wr_rdy_o) wr_st = 0;
            endcase
            serve_ar();
            serve_r();
            serve_write();
        end
        if (started == NUM_TXN && ic_st == 0 && dc_st == 0 && wr_st == 0
                && rq_id.size() == 0) begin
            $display("checks=%0d errors=%0d", chk_cnt, err_cnt);
            if (err_cnt == 0 && chk_cnt > 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end else if (cycles >= MAX_CYCLES) begin
            $display("timeout: transactions did not finish within %0d cycles", MAX_CYCLES);
            $display("checks=%0d errors=%0d", chk_cnt, err_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule

// ==== tb/bridge_checker.sv ====
`timescale 1ns/1ns

module bridge_checker (
    input logic aclk,
    input logic aresetn,
    input logic ic_rd_req_i, ic_rd_rdy_o, ic_ret_valid_o, ic_ret_last_o,
    input logic dc_rd_req_i, dc_rd_rdy_o, dc_ret_valid_o, dc_ret_last_o,
    input logic dc_wr_req_i, dc_wr_rdy_o,
    input axi_bridge_pkg::req_type_t ic_rd_type_i, dc_rd_type_i, dc_wr_type_i,
    input axi_bridge_pkg::addr_t     ic_addr_i, dc_addr_i, dc_wr_addr_i, araddr_o, awaddr_o,
    input axi_bridge_pkg::data_t     ic_data_o, dc_data_o, wdata_o,
    input axi_bridge_pkg::strb_t     dc_wr_strb_i, wstrb_o,
    input axi_bridge_pkg::line_t     dc_wr_line_i,
    input axi_bridge_pkg::axi_id_t   arid_o, rid_i,
    input axi_bridge_pkg::axi_len_t  arlen_o, awlen_o,
    input axi_bridge_pkg::axi_size_t arsize_o, awsize_o,
    input logic [1:0] arburst_o, awburst_o,
    input logic arvalid_o, arready_i, rvalid_i, rready_o,
    input logic awvalid_o, awready_i, wvalid_o, wready_i, wlast_o, bvalid_i, bready_o,
    output int  err_cnt,
    output int  chk_cnt
);

    logic [32:0] ic_exp[$];   // {last, beat address}
    logic [32:0] dc_exp[$];
    logic [33:0] ar_exp[$];   // {src, line, address} in grant order
    logic [32:0] e;
    logic [33:0] a;
    axi_bridge_pkg::addr_t    ic_req_addr, dc_req_addr, w_addr;
    logic                     ic_req_line, dc_req_line;
    axi_bridge_pkg::axi_len_t exp_len, w_len;
    axi_bridge_pkg::strb_t    w_strb;
    axi_bridge_pkg::line_t    w_line;
    int   w_beat;
    logic w_pend, arvalid_q, rst_done, ic_rdy_q, dc_rdy_q;

    initial begin
        err_cnt   = 0;
        chk_cnt   = 0;
        w_beat    = 0;
        w_pend    = 1'b0;
        arvalid_q = 1'b0;
        rst_done  = 1'b0;
        ic_rdy_q  = 1'b0;
        dc_rdy_q  = 1'b0;
    end

    task check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        chk_cnt++;
        if (exp !== got) begin
            err_cnt++;
            $display("[FAIL] %s expected %h got %h", name, exp, got);
        end
    endtask

    task note_error(input string msg);
        err_cnt++;
        $display("error: %s", msg);
    endtask

    always @(posedge aclk) begin
        if (aresetn && !rst_done) begin
            rst_done = 1'b1;
            check_val("arvalid_o", 0, arvalid_o);
            check_val("awvalid_o", 0, awvalid_o);
            check_val("wvalid_o", 0, wvalid_o);
            check_val("wlast_o", 0, wlast_o);
            check_val("bready_o", 0, bready_o);
            check_val("rready_o", 0, rready_o);
            check_val("ic_rd_rdy_o", 1, ic_rd_rdy_o);
            check_val("dc_rd_rdy_o", 1, dc_rd_rdy_o);
            check_val("dc_wr_rdy_o", 1, dc_wr_rdy_o);
        end else if (aresetn) begin
            if (ic_rd_req_i) begin
                ic_req_addr = ic_addr_i;
                ic_req_line = (ic_rd_type_i == axi_bridge_pkg::REQ_LINE);
            end
            if (dc_rd_req_i) begin
                dc_req_addr = dc_addr_i;
                dc_req_line = (dc_rd_type_i == axi_bridge_pkg::REQ_LINE);
            end
            // rd_rdy drops the cycle after a grant
            if (ic_rdy_q && !ic_rd_rdy_o) begin
                ar_exp.push_back({1'b0, ic_req_line, ic_req_addr});
            end
            if (dc_rdy_q && !dc_rd_rdy_o) begin
                ar_exp.push_back({1'b1, dc_req_line, dc_req_addr});
            end
            if (w_pend && arvalid_o && !arvalid_q)
                note_error("arvalid rose while a write was pending");
            if (arvalid_o && arready_i) begin
                if (ar_exp.size() == 0) begin
                    note_error("AR issued with no read granted");
                end else begin
                    a = ar_exp.pop_front();
                    exp_len = a[32] ? 8'd3 : 8'd0;
                    check_val("arid_o", {31'd0, a[33]}, arid_o);
                    check_val("araddr_o", a[31:0], araddr_o);
                    check_val("arlen_o", exp_len, arlen_o);
                    check_val("arsize_o", 2, arsize_o);
                    check_val("arburst_o", 1, arburst_o);
                    for (int i = 0; i <= exp_len; i++) begin
                        if (a[33]) dc_exp.push_back({i == exp_len, a[31:0] + 32'(4 * i)});
                        else ic_exp.push_back({i == exp_len, a[31:0] + 32'(4 * i)});
                    end
                end
            end
            // source stays not ready while beats are owed to it
            if (ic_exp.size() > 0 && ic_rd_rdy_o) note_error("ic_rd_rdy high during a read");
            if (dc_exp.size() > 0 && dc_rd_rdy_o) note_error("dc_rd_rdy high during a read");
            if (rvalid_i && rready_o && !ic_ret_valid_o && !dc_ret_valid_o)
                note_error("R beat reached neither cache");
            if (ic_ret_valid_o) begin
                if (ic_exp.size() == 0) begin
                    note_error("instruction cache got a beat with no read outstanding");
                end else begin
                    e = ic_exp.pop_front();
                    check_val("ic_data_o", e[31:0] ^ 32'h5A5A0000, ic_data_o);
                    check_val("ic_ret_last_o", e[32], ic_ret_last_o);
                    check_val("rid_i", 0, rid_i);
                end
            end
            if (dc_ret_valid_o) begin
                if (dc_exp.size() == 0) begin
                    note_error("data cache got a beat with no read outstanding");
                end else begin
                    e = dc_exp.pop_front();
                    check_val("dc_data_o", e[31:0] ^ 32'h5A5A0000, dc_data_o);
                    check_val("dc_ret_last_o", e[32], dc_ret_last_o);
                    check_val("rid_i", 1, rid_i);
                end
            end
            if (w_pend && dc_wr_rdy_o) w_pend = 1'b0;
            if (dc_wr_req_i && dc_wr_rdy_o) begin
                w_pend = 1'b1;
                w_beat = 0;
                w_addr = dc_wr_addr_i;
                w_len  = (dc_wr_type_i == axi_bridge_pkg::REQ_LINE) ? 8'd3 : 8'd0;
                w_strb = dc_wr_strb_i;
                w_line = dc_wr_line_i;
            end
            if (awvalid_o && awready_i) begin
                check_val("awaddr_o", w_addr, awaddr_o);
                check_val("awlen_o", w_len, awlen_o);
                check_val("awsize_o", 2, awsize_o);
                check_val("awburst_o", 1, awburst_o);
            end
            if (wvalid_o && wready_i) begin
                check_val("wdata_o", w_line[w_beat * 32 +: 32], wdata_o);
                check_val("wstrb_o", w_strb, wstrb_o);
                check_val("wlast_o", w_beat == w_len, wlast_o);
                w_beat++;
            end
            if (bvalid_i && bready_o && w_beat != w_len + 1)
                note_error("B response came before all W beats were sent");
        end
        arvalid_q = arvalid_o;
        ic_rdy_q  = ic_rd_rdy_o;
        dc_rdy_q  = dc_rd_rdy_o;
    end

endmodule

// ==== rtl/axi_cache_bridge.sv ====
`timescale 1ns/1ns

module axi_cache_bridge (
    input  logic                      aclk,
    input  logic                      aresetn,
    // instruction cache
    input  logic                      ic_rd_req_i,
    input  axi_bridge_pkg::req_type_t ic_rd_type_i,
    input  axi_bridge_pkg::addr_t     ic_addr_i,
    output logic                      ic_rd_rdy_o,
    output logic                      ic_ret_valid_o,
    output logic                      ic_ret_last_o,
    output axi_bridge_pkg::data_t     ic_data_o,
    // data cache
    input  logic                      dc_rd_req_i,
    input  axi_bridge_pkg::req_type_t dc_rd_type_i,
    input  axi_bridge_pkg::addr_t     dc_addr_i,
    output logic                      dc_rd_rdy_o,
    output logic                      dc_ret_valid_o,
    output logic                      dc_ret_last_o,
    output axi_bridge_pkg::data_t     dc_data_o,
    input  logic                      dc_wr_req_i,
    input  axi_bridge_pkg::req_type_t dc_wr_type_i,
    input  axi_bridge_pkg::addr_t     dc_wr_addr_i,
    input  axi_bridge_pkg::strb_t     dc_wr_strb_i,
    input  axi_bridge_pkg::line_t     dc_wr_line_i,
    output logic                      dc_wr_rdy_o,
    // AXI
    output logic                      arvalid_o,
    input  logic                      arready_i,
    output axi_bridge_pkg::axi_id_t   arid_o,
    output axi_bridge_pkg::addr_t     araddr_o,
    output axi_bridge_pkg::axi_len_t  arlen_o,
    output axi_bridge_pkg::axi_size_t arsize_o,
    output logic [1:0]                arburst_o,
    input  logic                      rvalid_i,
    output logic                      rready_o,
    input  axi_bridge_pkg::axi_id_t   rid_i,
    input  axi_bridge_pkg::data_t     rdata_i,
    input  logic                      rlast_i,
    output logic                      awvalid_o,
    input  logic                      awready_i,
    output axi_bridge_pkg::addr_t     awaddr_o,
    output axi_bridge_pkg::axi_len_t  awlen_o,
    output axi_bridge_pkg::axi_size_t awsize_o,
    output logic [1:0]                awburst_o,
    output logic                      wvalid_o,
    input  logic                      wready_i,
    output axi_bridge_pkg::data_t     wdata_o,
    output axi_bridge_pkg::strb_t     wstrb_o,
    output logic                      wlast_o,
    input  logic                      bvalid_i,
    output logic                      bready_o
);

    logic                    grant;
    axi_bridge_pkg::rd_req_t grant_req;
    logic                    ar_busy;
    logic                    wr_block;
    logic                    inst_busy;
    logic                    data_busy;
    logic                    inst_done;
    logic                    data_done;

    read_arbiter u_read_arbiter (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .ic_rd_req_i  (ic_rd_req_i),
        .ic_rd_type_i (ic_rd_type_i),
        .ic_addr_i    (ic_addr_i),
        .dc_rd_req_i  (dc_rd_req_i),
        .dc_rd_type_i (dc_rd_type_i),
        .dc_addr_i    (dc_addr_i),
        .wr_block_i   (wr_block),
        .ar_busy_i    (ar_busy),
        .inst_done_i  (inst_done),
        .data_done_i  (data_done),
        .ic_rd_rdy_o  (ic_rd_rdy_o),
        .dc_rd_rdy_o  (dc_rd_rdy_o),
        .inst_busy_o  (inst_busy),
        .data_busy_o  (data_busy),
        .grant_o      (grant),
        .grant_req_o  (grant_req)
    );

    ar_issue u_ar_issue (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .grant_i     (grant),
        .grant_req_i (grant_req),
        .arready_i   (arready_i),
        .ar_busy_o   (ar_busy),
        .arvalid_o   (arvalid_o),
        .arid_o      (arid_o),
        .araddr_o    (araddr_o),
        .arlen_o     (arlen_o)
    );

    r_return u_r_return (
        .inst_busy_i    (inst_busy),
        .data_busy_i    (data_busy),
        .rvalid_i       (rvalid_i),
        .rid_i          (rid_i),
        .rdata_i        (rdata_i),
        .rlast_i        (rlast_i),
        .rready_o       (rready_o),
        .ic_ret_valid_o (ic_ret_valid_o),
        .ic_ret_last_o  (ic_ret_last_o),
        .ic_data_o      (ic_data_o),
        .dc_ret_valid_o (dc_ret_valid_o),
        .dc_ret_last_o  (dc_ret_last_o),
        .dc_data_o      (dc_data_o),
        .inst_done_o    (inst_done),
        .data_done_o    (data_done)
    );

    write_channel u_write_channel (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .wr_req_i   (dc_wr_req_i),
        .wr_type_i  (dc_wr_type_i),
        .wr_addr_i  (dc_wr_addr_i),
        .wr_strb_i  (dc_wr_strb_i),
        .wr_line_i  (dc_wr_line_i),
        .awready_i  (awready_i),
        .wready_i   (wready_i),
        .bvalid_i   (bvalid_i),
        .wr_rdy_o   (dc_wr_rdy_o),
        .wr_block_o (wr_block),
        .awvalid_o  (awvalid_o),
        .awaddr_o   (awaddr_o),
        .awlen_o    (awlen_o),
        .wvalid_o   (wvalid_o),
        .wdata_o    (wdata_o),
        .wstrb_o    (wstrb_o),
        .wlast_o    (wlast_o),
        .bready_o   (bready_o)
    );

    // every beat is a full 32-bit word, incrementing
    assign arsize_o  = axi_bridge_pkg::BEAT_SIZE;
    assign awsize_o  = axi_bridge_pkg::BEAT_SIZE;
    assign arburst_o = axi_bridge_pkg::BURST_INCR;
    assign awburst_o = axi_bridge_pkg::BURST_INCR;

endmodule

// ==== rtl/write_channel.sv ====
`timescale 1ns/1ns

module write_channel (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      wr_req_i,
    input  axi_bridge_pkg::req_type_t wr_type_i,
    input  axi_bridge_pkg::addr_t     wr_addr_i,
    input  axi_bridge_pkg::strb_t     wr_strb_i,
    input  axi_bridge_pkg::line_t     wr_line_i,
    input  logic                      awready_i,
    input  logic                      wready_i,
    input  logic                      bvalid_i,
    output logic                      wr_rdy_o,
    output logic                      wr_block_o,
    output logic                      awvalid_o,
    output axi_bridge_pkg::addr_t     awaddr_o,
    output axi_bridge_pkg::axi_len_t  awlen_o,
    output logic                      wvalid_o,
    output axi_bridge_pkg::data_t     wdata_o,
    output axi_bridge_pkg::strb_t     wstrb_o,
    output logic                      wlast_o,
    output logic                      bready_o
);

    axi_bridge_pkg::wr_state_t state;
    axi_bridge_pkg::axi_len_t  beat_cnt;

    // latched request
    axi_bridge_pkg::addr_t     addr_q;
    axi_bridge_pkg::axi_len_t  len_q;
    axi_bridge_pkg::strb_t     strb_q;
    axi_bridge_pkg::line_t     line_q;

    logic accept;
    logic w_fire;

    assign accept = (state == axi_bridge_pkg::W_IDLE) && wr_req_i;
    assign w_fire = (state == axi_bridge_pkg::W_DATA) && wready_i;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state    <= axi_bridge_pkg::W_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                axi_bridge_pkg::W_IDLE: begin
                    if (wr_req_i) begin
                        state <= axi_bridge_pkg::W_ADDR;
                    end
                end
                axi_bridge_pkg::W_ADDR: begin
                    if (awready_i) begin
                        state    <= axi_bridge_pkg::W_DATA;
                        beat_cnt <= '0;
                    end
                end
                axi_bridge_pkg::W_DATA: begin
                    if (wready_i) begin
                        if (beat_cnt == len_q) begin
                            state <= axi_bridge_pkg::W_RESP;
                        end else begin
                            beat_cnt <= beat_cnt + 8'd1;
                        end
                    end
                end
                axi_bridge_pkg::W_RESP: begin
                    if (bvalid_i) begin
                        state <= axi_bridge_pkg::W_IDLE;
                    end
                end
                default: state <= axi_bridge_pkg::W_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            addr_q <= wr_addr_i;
            strb_q <= wr_strb_i;
            line_q <= wr_line_i;
            if (wr_type_i == axi_bridge_pkg::REQ_LINE) begin
                len_q <= axi_bridge_pkg::LINE_LEN;
            end else begin
                len_q <= '0;
            end
        end else if (w_fire) begin
            line_q <= {32'd0, line_q[127:32]};   // next beat down to the low word
        end
    end

    assign wr_rdy_o   = (state == axi_bridge_pkg::W_IDLE);
    assign wr_block_o = (state != axi_bridge_pkg::W_IDLE) || wr_req_i;

    assign awvalid_o = (state == axi_bridge_pkg::W_ADDR);
    assign awaddr_o  = addr_q;
    assign awlen_o   = len_q;

    assign wvalid_o = (state == axi_bridge_pkg::W_DATA);
    assign wdata_o  = line_q[31:0];
    assign wstrb_o  = strb_q;
    assign wlast_o  = wvalid_o && (beat_cnt == len_q);

    // held from the AW handshake until the response
    assign bready_o = (state == axi_bridge_pkg::W_DATA) || (state == axi_bridge_pkg::W_RESP);

endmodule

// ==== rtl/r_return.sv ====
`timescale 1ns/1ns

module r_return (
    input  logic                    inst_busy_i,
    input  logic                    data_busy_i,
    input  logic                    rvalid_i,
    input  axi_bridge_pkg::axi_id_t rid_i,
    input  axi_bridge_pkg::data_t   rdata_i,
    input  logic                    rlast_i,
    output logic                    rready_o,
    output logic                    ic_ret_valid_o,
    output logic                    ic_ret_last_o,
    output axi_bridge_pkg::data_t   ic_data_o,
    output logic                    dc_ret_valid_o,
    output logic                    dc_ret_last_o,
    output axi_bridge_pkg::data_t   dc_data_o,
    output logic                    inst_done_o,
    output logic                    data_done_o
);

    logic ic_hit;
    logic dc_hit;

    // accept beats only while some read is outstanding
    assign rready_o = inst_busy_i || data_busy_i;

    // low id bit selects the cache
    assign ic_hit = rvalid_i && inst_busy_i && (rid_i[0] == axi_bridge_pkg::ID_INST[0]);
    assign dc_hit = rvalid_i && data_busy_i && (rid_i[0] == axi_bridge_pkg::ID_DATA[0]);

    assign ic_ret_valid_o = ic_hit;
    assign ic_ret_last_o  = ic_hit && rlast_i;
    assign ic_data_o      = ic_hit ? rdata_i : '0;

    assign dc_ret_valid_o = dc_hit;
    assign dc_ret_last_o  = dc_hit && rlast_i;
    assign dc_data_o      = dc_hit ? rdata_i : '0;

    assign inst_done_o = ic_hit && rlast_i;   // clears busy in the arbiter
    assign data_done_o = dc_hit && rlast_i;

endmodule

// ==== rtl/ar_issue.sv ====
`timescale 1ns/1ns

module ar_issue (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      grant_i,
    input  axi_bridge_pkg::rd_req_t   grant_req_i,
    input  logic                      arready_i,
    output logic                      ar_busy_o,
    output logic                      arvalid_o,
    output axi_bridge_pkg::axi_id_t   arid_o,
    output axi_bridge_pkg::addr_t     araddr_o,
    output axi_bridge_pkg::axi_len_t  arlen_o
);

    axi_bridge_pkg::ar_state_t state;
    axi_bridge_pkg::rd_req_t   req_q;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= axi_bridge_pkg::AR_IDLE;
        end else begin
            case (state)
                axi_bridge_pkg::AR_IDLE: begin
                    if (grant_i) begin
                        state <= axi_bridge_pkg::AR_WAIT;
                    end
                end
                axi_bridge_pkg::AR_WAIT: begin
                    if (arready_i) begin
                        state <= axi_bridge_pkg::AR_IDLE;
                    end
                end
                default: state <= axi_bridge_pkg::AR_IDLE;
            endcase
        end
    end

    // payload held stable while waiting on arready
    always_ff @(posedge aclk) begin
        if (state == axi_bridge_pkg::AR_IDLE && grant_i) begin
            req_q <= grant_req_i;
        end
    end

    assign ar_busy_o = (state == axi_bridge_pkg::AR_WAIT);
    assign arvalid_o = (state == axi_bridge_pkg::AR_WAIT);

    assign arid_o   = req_q.src ? axi_bridge_pkg::ID_DATA : axi_bridge_pkg::ID_INST;
    assign araddr_o = req_q.addr;
    assign arlen_o  = req_q.len;

endmodule

// ==== rtl/read_arbiter.sv ====
`timescale 1ns/1ns

module read_arbiter (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      ic_rd_req_i,
    input  axi_bridge_pkg::req_type_t ic_rd_type_i,
    input  axi_bridge_pkg::addr_t     ic_addr_i,
    input  logic                      dc_rd_req_i,
    input  axi_bridge_pkg::req_type_t dc_rd_type_i,
    input  axi_bridge_pkg::addr_t     dc_addr_i,
    input  logic                      wr_block_i,
    input  logic                      ar_busy_i,
    input  logic                      inst_done_i,
    input  logic                      data_done_i,
    output logic                      ic_rd_rdy_o,
    output logic                      dc_rd_rdy_o,
    output logic                      inst_busy_o,
    output logic                      data_busy_o,
    output logic                      grant_o,
    output axi_bridge_pkg::rd_req_t   grant_req_o
);

    logic inst_busy;
    logic data_busy;
    logic ic_go;
    logic dc_go;

    function automatic axi_bridge_pkg::axi_len_t burst_len(axi_bridge_pkg::req_type_t t);
        if (t == axi_bridge_pkg::REQ_LINE) begin
            return axi_bridge_pkg::LINE_LEN;
        end
        return '0;
    endfunction

    // no new read while a write is pending or AR is occupied
    assign ic_go = ic_rd_req_i && !inst_busy && !wr_block_i && !ar_busy_i;
    assign dc_go = dc_rd_req_i && !data_busy && !wr_block_i && !ar_busy_i;

    assign grant_o = ic_go || dc_go;

    always_comb begin
        if (ic_go) begin                  // instruction fetch wins ties
            grant_req_o.src  = 1'b0;
            grant_req_o.addr = ic_addr_i;
            grant_req_o.len  = burst_len(ic_rd_type_i);
        end else begin
            grant_req_o.src  = 1'b1;
            grant_req_o.addr = dc_addr_i;
            grant_req_o.len  = burst_len(dc_rd_type_i);
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            inst_busy <= 1'b0;
            data_busy <= 1'b0;
        end else begin
            if (ic_go) begin
                inst_busy <= 1'b1;
            end else if (inst_done_i) begin
                inst_busy <= 1'b0;
            end

            if (dc_go && !ic_go) begin
                data_busy <= 1'b1;
            end else if (data_done_i) begin
                data_busy <= 1'b0;
            end
        end
    end

    assign ic_rd_rdy_o = !inst_busy;
    assign dc_rd_rdy_o = !data_busy;
    assign inst_busy_o = inst_busy;
    assign data_busy_o = data_busy;

endmodule

// ==== rtl/axi_bridge_pkg.sv ====
package axi_bridge_pkg;

    // widths fixed by the 32-bit AXI bus
    typedef logic [31:0]  addr_t;
    typedef logic [31:0]  data_t;
    typedef logic [127:0] line_t;     // four beats, low word first
    typedef logic [3:0]   strb_t;
    typedef logic [7:0]   axi_len_t;
    typedef logic [3:0]   axi_id_t;
    typedef logic [2:0]   axi_size_t;
    typedef logic [2:0]   req_type_t;

    // cache request types
    localparam req_type_t REQ_WORD = 3'd0;
    localparam req_type_t REQ_LINE = 3'd4;

    localparam axi_len_t  LINE_LEN   = 8'd3;   // four beats
    localparam axi_size_t BEAT_SIZE  = 3'd2;   // four bytes per beat
    localparam logic [1:0] BURST_INCR = 2'b01;

    // read ids, low bit picks the cache on return
    localparam axi_id_t ID_INST = 4'd0;
    localparam axi_id_t ID_DATA = 4'd1;

    typedef struct packed {
        logic     src;    // 0 inst, 1 data
        addr_t    addr;
        axi_len_t len;
    } rd_req_t;

    typedef enum logic [1:0] {
        W_IDLE,
        W_ADDR,
        W_DATA,
        W_RESP
    } wr_state_t;

    typedef enum logic {
        AR_IDLE,
        AR_WAIT
    } ar_state_t;

endpackage
